/* retire_macros.svh */
`ifndef RETIRE_MACROS_SVH
`define RETIRE_MACROS_SVH

// Data word width.
`define XLEN 32

// Writeback slots and commit slots per cycle.
`define COMMIT_WIDTH 2

`define NUM_ARCH_REGS 32

// Retire queue entries. Must be a power of two so that the pointers wrap naturally.
`define RETIRE_DEPTH 8

`endif

/* retire_pkg.sv */
`include "retire_macros.svh"

package retire_pkg;

    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] ilr_idx_t;

    typedef logic [`XLEN-1:0] xword_t;

    // One result waiting for retirement.
    typedef struct packed {
        ilr_idx_t idx;
        xword_t   data;
    } commit_entry_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMMIT,
        ST_FLUSH
    } retire_state_t;

    // Wide enough to hold a full queue.
    typedef logic [$clog2(`RETIRE_DEPTH + 1)-1:0] cnt_t;

endpackage

/* queue_ctrl_if.sv */
`timescale 1ns/1ps

interface queue_ctrl_if import retire_pkg::*; ();

    cnt_t count;    // Queue occupancy.
    cnt_t pop_cnt;  // Entries removed at the next edge.
    logic clear;    // Drop every entry at the next edge.
    logic full;

    modport ctrl (
        input  count,
        output pop_cnt,
        output clear
    );

    modport queue (
        output count,
        output full,
        input  pop_cnt,
        input  clear
    );

endinterface

/* retire_queue.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_queue import retire_pkg::*; #(
    parameter type entry_t = commit_entry_t
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push_vld   [`COMMIT_WIDTH],
    input  entry_t push_entry [`COMMIT_WIDTH],
    output logic   head_vld   [`COMMIT_WIDTH],
    output entry_t head_entry [`COMMIT_WIDTH],
    queue_ctrl_if.queue qc
);

    localparam int PTR_W = $clog2(`RETIRE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    entry_t mem [`RETIRE_DEPTH];
    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    cnt_t   count;
    cnt_t   push_cnt;
    ptr_t   wr_idx [`COMMIT_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Push side
    //////////////////////////////////////////////////////////////////////

    // Valid slots are packed onto the tail in ascending slot order.
    always_comb begin
        cnt_t n;
        n = '0;
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            wr_idx[k] = ptr_t'(wr_ptr + n);
            if (push_vld[k]) n = n + 1'b1;
        end
        push_cnt = n;
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            if (push_vld[k] && !qc.clear) mem[wr_idx[k]] <= push_entry[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || qc.clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= ptr_t'(rd_ptr + qc.pop_cnt);
            wr_ptr <= ptr_t'(wr_ptr + push_cnt);
            count  <= count + push_cnt - qc.pop_cnt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Head window
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            head_vld[k]   = (count > cnt_t'(k));
            head_entry[k] = mem[ptr_t'(rd_ptr + k)];
        end
    end

    assign qc.count = count;
    assign qc.full  = (count == cnt_t'(`RETIRE_DEPTH));

    // Writeback has no back-pressure, so the queue must never overflow.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !qc.clear |-> int'(count) + int'(push_cnt) <= `RETIRE_DEPTH + int'(qc.pop_cnt));

    a_pop_in_range: assert property (@(posedge clk) disable iff (rst)
        qc.pop_cnt <= count);

endmodule

/* retire_ctrl.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_ctrl import retire_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    queue_ctrl_if.ctrl qc,
    input  logic head_vld   [`COMMIT_WIDTH],
    output logic commit_vld [`COMMIT_WIDTH],
    output logic idle
);

    retire_state_t state;
    retire_state_t state_nxt;
    cnt_t          pop_cnt;

    // Commit every valid head entry unless held by stall or a pending flush.
    always_comb begin
        cnt_t n;
        n = '0;
        if (state != ST_FLUSH && !stall) begin
            for (int k = 0; k < `COMMIT_WIDTH; k++) begin
                if (head_vld[k]) n = n + 1'b1;
            end
        end
        pop_cnt = n;
    end

    always_comb begin
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            commit_vld[k] = (cnt_t'(k) < pop_cnt);
        end
    end

    always_comb begin
        if (flush)
            state_nxt = ST_FLUSH;
        else if (state == ST_FLUSH)
            state_nxt = ST_IDLE;  // The queue is empty after the clear edge.
        else if (qc.count != pop_cnt)
            state_nxt = ST_COMMIT;
        else
            state_nxt = ST_IDLE;
    end

    always_ff @(posedge clk) begin
        if (rst) state <= ST_IDLE;
        else     state <= state_nxt;
    end

    assign qc.pop_cnt = pop_cnt;
    assign qc.clear   = (state == ST_FLUSH);
    assign idle       = (state == ST_IDLE) && (qc.count == '0);

    a_clear_no_pop: assert property (@(posedge clk) disable iff (rst)
        qc.clear |-> qc.pop_cnt == '0);

endmodule

/* perf_counter.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module perf_counter import retire_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   commit_vld [`COMMIT_WIDTH],
    output xword_t cycle_count,
    output xword_t retire_count
);

    xword_t commit_num;

    always_comb begin
        commit_num = '0;
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            if (commit_vld[k]) commit_num = commit_num + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count  <= '0;
            retire_count <= '0;
        end else begin
            cycle_count  <= cycle_count + 1'b1;
            retire_count <= retire_count + commit_num;  // Same edge as the commit.
        end
    end

endmodule

/* arch_regfile.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module arch_regfile import retire_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          commit_vld   [`COMMIT_WIDTH],
    input  commit_entry_t commit_entry [`COMMIT_WIDTH],
    input  ilr_idx_t      rd_idx,
    output xword_t        rd_data
);

    xword_t regs [`NUM_ARCH_REGS];

    //////////////////////////////////////////////////////////////////////
    // Commit writes
    //////////////////////////////////////////////////////////////////////

    // Slots go in ascending order, so a later slot overrides an earlier one.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < `COMMIT_WIDTH; k++) begin
                if (commit_vld[k] && commit_entry[k].idx != '0) begin
                    regs[commit_entry[k].idx] <= commit_entry[k].data;
                end
            end
        end
    end

    // x0 is never written and so stays zero after reset.
    assign rd_data = regs[rd_idx];

endmodule

/* retire_top.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_top import retire_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  logic     wb_vld  [`COMMIT_WIDTH],
    input  ilr_idx_t wb_idx  [`COMMIT_WIDTH],
    input  xword_t   wb_data [`COMMIT_WIDTH],
    input  ilr_idx_t rd_idx,
    output xword_t   rd_data,
    output logic     idle,
    output logic     full,
    output xword_t   cycle_count,
    output xword_t   retire_count
);

    commit_entry_t push_entry [`COMMIT_WIDTH];
    commit_entry_t head_entry [`COMMIT_WIDTH];
    logic          head_vld   [`COMMIT_WIDTH];
    logic          commit_vld [`COMMIT_WIDTH];

    queue_ctrl_if qc ();

    always_comb begin
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            push_entry[k].idx  = wb_idx[k];
            push_entry[k].data = wb_data[k];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire pipeline
    //////////////////////////////////////////////////////////////////////

    retire_queue #(.entry_t(commit_entry_t)) u_queue (
        .clk        (clk),
        .rst        (rst),
        .push_vld   (wb_vld),
        .push_entry (push_entry),
        .head_vld   (head_vld),
        .head_entry (head_entry),
        .qc         (qc.queue)
    );

    retire_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .qc         (qc.ctrl),
        .head_vld   (head_vld),
        .commit_vld (commit_vld),
        .idle       (idle)
    );

    perf_counter u_perf (
        .clk          (clk),
        .rst          (rst),
        .commit_vld   (commit_vld),
        .cycle_count  (cycle_count),
        .retire_count (retire_count)
    );

    arch_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .commit_vld   (commit_vld),
        .commit_entry (head_entry),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data)
    );

    assign full = qc.full;

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_NS = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;  // 8 ns period with the default.

endmodule

/* tb_retire.sv */
`timescale 1ns/1ps
`include "retire_macros.svh"

module tb_retire import retire_pkg::*; ();

    localparam int FIELDS  = 7;  // Words per stim line.
    localparam int MAX_OPS = 128;

    logic          clk;
    logic          rst;
    logic          stall;
    logic          flush;
    logic          wb_vld  [`COMMIT_WIDTH];
    ilr_idx_t      wb_idx  [`COMMIT_WIDTH];
    xword_t        wb_data [`COMMIT_WIDTH];
    ilr_idx_t      rd_idx;
    xword_t        rd_data;
    logic          idle;
    logic          full;
    xword_t        cycle_count;
    xword_t        retire_count;

    logic [31:0]   stim [FIELDS*MAX_OPS];
    xword_t        model_regs [`NUM_ARCH_REGS];
    commit_entry_t pending [$];  // Pushed in order, not yet retired by the model.
    xword_t        model_count;
    xword_t        model_cycles;  // Clock edges since reset was released.
    integer        seed = 24;
    int            n_ops;
    int            limit_cycles = 0;
    int            errors = 0;
    int            test_errors = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;

    tb_clkgen u_clk (.clk(clk));

    retire_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .wb_vld       (wb_vld),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .idle         (idle),
        .full         (full),
        .cycle_count  (cycle_count),
        .retire_count (retire_count)
    );

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_reg(input ilr_idx_t idx, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERROR rd_data[x%0d]: got 0x%h, expected 0x%h", idx, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drivers and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
        model_cycles++;
    endtask

    task automatic read_reg(input ilr_idx_t idx, output xword_t val);
        rd_idx = idx;
        #0.05;
        val = rd_data;
    endtask

    task automatic drive_wb(input logic v0, input ilr_idx_t i0, input xword_t d0,
                            input logic v1, input ilr_idx_t i1, input xword_t d1);
        wb_vld[0]  = v0;
        wb_idx[0]  = i0;
        wb_data[0] = d0;
        wb_vld[1]  = v1;
        wb_idx[1]  = i1;
        wb_data[1] = d1;
        if (v0) pending.push_back('{idx: i0, data: d0});  // Slot order is queue order.
        if (v1) pending.push_back('{idx: i1, data: d1});
        next_cycle();
        wb_vld[0] = 1'b0;
        wb_vld[1] = 1'b0;
    endtask

    task automatic random_wb(input int cycles);
        int       r;
        ilr_idx_t i0;
        ilr_idx_t i1;
        xword_t   d0;
        xword_t   d1;
        repeat (cycles) begin
            r  = $random(seed);
            i0 = ilr_idx_t'($random(seed));
            d0 = $random(seed);
            i1 = ilr_idx_t'($random(seed));
            d1 = $random(seed);
            drive_wb(r[0], i0, d0, r[1], i1, d1);
        end
    endtask

    // Retirement is in order, so applying the pending list in order gives the final state.
    task automatic commit_model();
        foreach (pending[n]) begin
            if (pending[n].idx != '0) model_regs[pending[n].idx] = pending[n].data;
            model_count++;
        end
        pending.delete();
    endtask

    task automatic end_test(input int num);
        if (test_errors == 0) begin
            $display("Test %0d: pass", num);
            tests_passed++;
        end else begin
            $display("Test %0d: fail with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int     op;
        int     base;
        xword_t val;
        rst    = 1'b1;
        stall  = 1'b0;
        flush  = 1'b0;
        rd_idx = '0;
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            wb_vld[k]  = 1'b0;
            wb_idx[k]  = '0;
            wb_data[k] = '0;
        end
        for (int r = 0; r < `NUM_ARCH_REGS; r++) model_regs[r] = '0;
        model_count  = '0;
        model_cycles = '0;
        $readmemh("retire_stim.txt", stim);
        n_ops = 0;
        while (n_ops < MAX_OPS && stim[FIELDS*n_ops] !== 32'hf) n_ops++;
        if (n_ops == MAX_OPS) begin
            $display("The stim file has no end marker, so no operation was run");
            errors++;
            n_ops = 0;
        end
        limit_cycles = n_ops * 20 + 100;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            base = FIELDS * i;
            op   = stim[base];
            case (op)
                'h1: drive_wb(stim[base+1][0], stim[base+2][4:0], stim[base+3],
                              stim[base+4][0], stim[base+5][4:0], stim[base+6]);
                'h2: begin
                    stall = stim[base+1][0];
                    next_cycle();
                end
                'h3: begin
                    flush = 1'b1;
                    pending.delete();  // Everything still queued is dropped.
                    next_cycle();
                    flush = 1'b0;
                end
                'h4: begin
                    while (!idle) next_cycle();
                    commit_model();
                end
                'h5: begin
                    read_reg(stim[base+2][4:0], val);
                    check_reg(stim[base+2][4:0], val, stim[base+3]);
                    next_cycle();
                end
                'h6: begin
                    check_count("retire_count", retire_count, model_count);
                    check_count("cycle_count", cycle_count, model_cycles);
                    next_cycle();
                end
                'h7: begin
                    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                        read_reg(ilr_idx_t'(r), val);
                        check_reg(ilr_idx_t'(r), val, model_regs[r]);
                    end
                    next_cycle();
                end
                'h8: begin
                    check_flag("idle", idle, stim[base+1][0]);
                    check_flag("full", full, stim[base+4][0]);
                    next_cycle();
                end
                'ha: random_wb(stim[base+3]);
                'h0: end_test(stim[base+2]);
                default: begin
                    $display("Stim line %0d holds an unknown operation %h", i, op);
                    errors++;
                end
            endcase
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Ends a run that hangs, for example on an idle that never rises.
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* retire_stim.txt */
// Columns: op v0 i0 d0 v1 i1 d1 in hex. Ops: 1 wb, 2 stall v0, 3 flush, 4 wait idle,
// 5 reg i0 is d0, 6 count, 7 all regs, 8 flags v0 idle v1 full, a d0 random, 0 end i0, f end.
7 0 00 00000000 0 00 00000000
8 1 00 00000000 0 00 00000000
6 0 00 00000000 0 00 00000000
0 0 01 00000000 0 00 00000000
1 1 01 11111111 0 00 00000000
1 1 02 22220001 1 03 33330003
1 1 05 0000aaaa 1 05 0000bbbb
4 0 00 00000000 0 00 00000000
5 0 05 0000bbbb 0 00 00000000
5 0 03 33330003 0 00 00000000
7 0 00 00000000 0 00 00000000
0 0 02 00000000 0 00 00000000
1 1 00 deadbeef 1 04 44440004
4 0 00 00000000 0 00 00000000
5 0 00 00000000 0 00 00000000
5 0 04 44440004 0 00 00000000
6 0 00 00000000 0 00 00000000
0 0 03 00000000 0 00 00000000
1 1 06 60000006 0 00 00000000
4 0 00 00000000 0 00 00000000
2 1 00 00000000 0 00 00000000
1 1 07 70000007 0 00 00000000
1 1 08 80000008 0 00 00000000
1 1 09 90000009 0 00 00000000
1 1 0a a000000a 0 00 00000000
1 1 0b b000000b 0 00 00000000
1 0 00 00000000 1 0c c000000c
1 1 0d d000000d 0 00 00000000
8 0 00 00000000 0 00 00000000
1 1 07 77777777 0 00 00000000
8 0 00 00000000 1 00 00000000
5 0 07 00000000 0 00 00000000
7 0 00 00000000 0 00 00000000
2 0 00 00000000 0 00 00000000
4 0 00 00000000 0 00 00000000
5 0 07 77777777 0 00 00000000
5 0 0c c000000c 0 00 00000000
7 0 00 00000000 0 00 00000000
6 0 00 00000000 0 00 00000000
0 0 04 00000000 0 00 00000000
2 1 00 00000000 0 00 00000000
1 1 01 f1f1f1f1 1 02 f2f2f2f2
1 1 03 f3f3f3f3 0 00 00000000
3 0 00 00000000 0 00 00000000
2 0 00 00000000 0 00 00000000
4 0 00 00000000 0 00 00000000
8 1 00 00000000 0 00 00000000
5 0 01 11111111 0 00 00000000
5 0 02 22220001 0 00 00000000
7 0 00 00000000 0 00 00000000
6 0 00 00000000 0 00 00000000
0 0 05 00000000 0 00 00000000
a 0 00 00000008 0 00 00000000
4 0 00 00000000 0 00 00000000
7 0 00 00000000 0 00 00000000
6 0 00 00000000 0 00 00000000
0 0 06 00000000 0 00 00000000
f 0 00 00000000 0 00 00000000

/* flist.f */
+incdir+.
retire_pkg.sv
queue_ctrl_if.sv
retire_queue.sv
retire_ctrl.sv
perf_counter.sv
arch_regfile.sv
retire_top.sv
tb_clkgen.sv
tb_retire.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_retire -o sim_retire
./obj_dir/sim_retire | tee sim.log

grep -q "Finished with no errors" sim.log
